// File: build.f
+incdir+hdl
hdl/bridge_pkg.sv
hdl/mem_req_router.sv
hdl/mem_rsp_merge.sv
hdl/launch_ctrl.sv
hdl/gpu_mem_bridge.sv
tests/tb_gpu_mem_bridge.sv

// File: Bender.yml
package:
  name: gpu_mem_bridge

export_include_dirs:
  - hdl

sources:
  - hdl/bridge_pkg.sv
  - hdl/mem_req_router.sv
  - hdl/mem_rsp_merge.sv
  - hdl/launch_ctrl.sv
  - hdl/gpu_mem_bridge.sv
  - target: test
    files:
      - tests/tb_gpu_mem_bridge.sv

// File: tests/tb_gpu_mem_bridge.sv
`default_nettype none

`include "bridge_params.svh"

module tb_gpu_mem_bridge;

    timeunit 1ns;
    timeprecision 1ps;

    import bridge_pkg::*;

    localparam int CLK_PERIOD = 100;
    // inputs settle well before the next rising edge
    localparam int SETTLE     = 25;
    localparam int TIMEOUT    = 50;
    localparam logic [31:0] LOCAL_BASE = `LOCAL_BASE_ADDR;
    localparam logic [`CSR_ADDR_BITS-1:0] BUSY_OFS  = `CSR_BUSY_OFS;
    localparam logic [`CSR_ADDR_BITS-1:0] START_OFS = `CSR_START_OFS;
    localparam logic [`CSR_ADDR_BITS-1:0] PC_OFS    = `CSR_PC_OFS;

    // starts low without an edge at time zero
    logic        clk = 1'b0;
    logic        nRST;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_req_ready;
    logic        mem_rsp_valid;
    mem_rsp_t    mem_rsp;
    logic        mem_rsp_ready;
    logic        local_req_valid;
    mem_req_t    local_req;
    logic        local_req_ready;
    logic        local_rsp_valid;
    mem_rsp_t    local_rsp;
    logic        local_rsp_ready;
    logic        ext_req_valid;
    mem_req_t    ext_req;
    logic        ext_req_ready;
    logic        ext_rsp_valid;
    mem_rsp_t    ext_rsp;
    logic        ext_rsp_ready;
    csr_req_t    csr_req;
    logic [31:0] csr_rdata;
    logic        gpu_busy;
    logic        gpu_reset;
    logic [31:0] gpu_pc_reset_val;

    logic [31:0] lfsr_state;
    int          value_errors;
    int          other_errors;
    // responses in the order the core must see them
    mem_rsp_t    exp_q[$];

    gpu_mem_bridge dut_i (.*);

    initial
    begin
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    //////////////////////////////////////////////////
    // random source and error reporting
    //////////////////////////////////////////////////

    // 32-bit fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[62:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    task automatic report_mismatch(input string msg);
        value_errors++;
        $display("[FAIL] %0t ns: %s", $time, msg);
    endtask

    task automatic report_problem(input string msg);
        other_errors++;
        $display("ERROR at %0t ns: %s", $time, msg);
    endtask

    //////////////////////////////////////////////////
    // always-on checks
    //////////////////////////////////////////////////

    // router is pure logic of the request inputs
    assert property (@(posedge clk) !(local_req_valid && ext_req_valid))
        else report_mismatch("local and external request valid both high");
    assert property (@(posedge clk) (local_req_valid | ext_req_valid) == mem_req_valid)
        else report_mismatch("request valid not steered to one target");
    assert property (@(posedge clk) mem_req_ready == (local_req_ready & ext_req_ready))
        else report_mismatch("mem_req_ready is not the AND of both readies");
    assert property (@(posedge clk) (local_req == mem_req) && (ext_req == mem_req))
        else report_mismatch("request payload not copied to both responders");
    // core back-pressure reaches both responders
    assert property (@(posedge clk)
                     (local_rsp_ready == mem_rsp_ready) && (ext_rsp_ready == mem_rsp_ready))
        else report_mismatch("responder ready does not follow mem_rsp_ready");
    // a shown response may not vanish under back-pressure
    assert property (@(posedge clk) disable iff (!nRST)
                     mem_rsp_valid && !mem_rsp_ready |=> mem_rsp_valid)
        else report_mismatch("response dropped while mem_rsp_ready low");

    // scoreboard, catches loss, duplicates and order
    always @(posedge clk)
    begin
        if (nRST && mem_rsp_valid && mem_rsp_ready)
        begin
            if (exp_q.size() == 0)
            begin
                report_problem($sformatf("core got tag %02h that no responder sent",
                                         mem_rsp.tag));
            end
            else
            begin
                assert (mem_rsp == exp_q[0])
                    else report_mismatch($sformatf("response tag %02h, expected %02h",
                                                   mem_rsp.tag, exp_q[0].tag));
                void'(exp_q.pop_front());
            end
        end
    end

    //////////////////////////////////////////////////
    // responder model and host tasks
    //////////////////////////////////////////////////

    // answer after delay falling edges, hold until the core is ready
    task automatic respond(input bit to_local, input mem_rsp_t rsp, input int delay,
                           input bit direct);
        int waited;
        repeat (delay)
        begin
            @(negedge clk);
        end
        if (to_local)
        begin
            local_rsp_valid = 1'b1;
            local_rsp       = rsp;
        end
        else
        begin
            ext_rsp_valid = 1'b1;
            ext_rsp       = rsp;
        end
        if (direct)
        begin
            #SETTLE;
            assert (mem_rsp_valid && (mem_rsp == rsp))
                else report_mismatch($sformatf("tag %02h not passed through", rsp.tag));
        end
        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
        end
        while (!mem_rsp_ready && waited < TIMEOUT);
        if (!mem_rsp_ready)
        begin
            report_problem("responder timed out waiting for mem_rsp_ready");
        end
        @(negedge clk);
        local_rsp_valid = to_local ? 1'b0 : local_rsp_valid;
        ext_rsp_valid   = to_local ? ext_rsp_valid : 1'b0;
    endtask

    // sampled on falling edges, away from the monitor
    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            report_problem("timed out waiting for the core to receive all responses");
        end
    endtask

    task automatic csr_write(input logic [`CSR_ADDR_BITS-1:0] ofs, input logic [31:0] data,
                             input logic [3:0] strb);
        @(negedge clk);
        csr_req.wen    = 1'b1;
        csr_req.ren    = 1'b0;
        csr_req.addr   = ofs;
        csr_req.wdata  = data;
        csr_req.strobe = strb;
        @(negedge clk);
        csr_req.wen = 1'b0;
        #SETTLE;
    endtask

    task automatic csr_read(input logic [`CSR_ADDR_BITS-1:0] ofs, output logic [31:0] data);
        @(negedge clk);
        csr_req.ren  = 1'b1;
        csr_req.wen  = 1'b0;
        csr_req.addr = ofs;
        #SETTLE;
        data = csr_rdata;
        @(negedge clk);
        csr_req.ren = 1'b0;
        #SETTLE;
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial
    begin
        mem_req_t    req;
        mem_rsp_t    l_rsp;
        mem_rsp_t    e_rsp;
        logic [31:0] byte_addr;
        logic        exp_local;
        logic [31:0] wd;
        logic [31:0] rd;
        logic [31:0] exp_pc;
        logic [3:0]  strb;
        int          hold;

        lfsr_state      = 32'hde09_6edc;
        value_errors    = 0;
        other_errors    = 0;
        nRST            = 1'b0;
        mem_req_valid   = 1'b0;
        mem_req         = '0;
        mem_rsp_ready   = 1'b0;
        local_req_ready = 1'b0;
        ext_req_ready   = 1'b0;
        local_rsp_valid = 1'b0;
        local_rsp       = '0;
        ext_rsp_valid   = 1'b0;
        ext_rsp         = '0;
        csr_req         = '0;
        gpu_busy        = 1'b0;

        // core held in reset, no response while nRST low
        repeat (8) @(negedge clk);
        #SETTLE;
        assert (gpu_reset && !mem_rsp_valid)
            else report_mismatch("gpu_reset low or response valid during reset");
        repeat (8) @(negedge clk);
        nRST = 1'b1;
        #SETTLE;
        assert (gpu_reset) else report_mismatch("gpu_reset low after reset");
        assert (gpu_pc_reset_val == `PC_RESET_DEFAULT)
            else report_mismatch($sformatf("pc after reset %08h", gpu_pc_reset_val));
        assert (!mem_rsp_valid) else report_mismatch("response valid after reset");

        // routing, every third address forced into the window
        local_req_ready = 1'b1;
        ext_req_ready   = 1'b1;
        for (int i = 0; i < 48; i++)
        begin
            @(negedge clk);
            req.rw     = 1'(take_bits(1));
            req.byteen = `MEM_BYTEEN_WIDTH'(take_bits(`MEM_BYTEEN_WIDTH));
            req.addr   = `MEM_ADDR_WIDTH'(take_bits(`MEM_ADDR_WIDTH));
            req.data   = `MEM_DATA_WIDTH'(take_bits(`MEM_DATA_WIDTH));
            req.tag    = `MEM_TAG_WIDTH'(take_bits(`MEM_TAG_WIDTH));
            if (i % 3 == 0)
            begin
                req.addr[`MEM_ADDR_WIDTH-1:`LOCAL_SPACE_BITS-`LINE_OFFSET_BITS] =
                    LOCAL_BASE[31:`LOCAL_SPACE_BITS];
            end
            mem_req       = req;
            mem_req_valid = 1'(take_bits(1));
            byte_addr     = {req.addr, {`LINE_OFFSET_BITS{1'b0}}};
            exp_local     = (byte_addr[31:`LOCAL_SPACE_BITS] == LOCAL_BASE[31:`LOCAL_SPACE_BITS]);
            #SETTLE;
            assert (local_req_valid == (mem_req_valid && exp_local)
                    && ext_req_valid == (mem_req_valid && !exp_local))
                else report_mismatch($sformatf("address %08h routed wrong", byte_addr));
            assert ((local_req == req) && (ext_req == req))
                else report_mismatch("request payload differs from mem_req");
        end

        // ready, all four combinations, only 2'b11 is ready
        for (int i = 0; i < 4; i++)
        begin
            @(negedge clk);
            local_req_ready = i[1];
            ext_req_ready   = i[0];
            #SETTLE;
            assert (mem_req_ready == (i == 3))
                else report_mismatch($sformatf("mem_req_ready wrong for readies %0d", i));
        end
        @(negedge clk);
        mem_req_valid = 1'b0;

        // single responses, alternating sides, random delay
        mem_rsp_ready = 1'b1;
        for (int i = 0; i < 6; i++)
        begin
            l_rsp.data = `MEM_DATA_WIDTH'(take_bits(`MEM_DATA_WIDTH));
            l_rsp.tag  = `MEM_TAG_WIDTH'(take_bits(`MEM_TAG_WIDTH));
            exp_q.push_back(l_rsp);
            respond(i[0], l_rsp, int'(take_bits(2)), 1'b1);
        end
        wait_drained();

        // collisions, external entry held under back-pressure
        for (int k = 0; k < 3; k++)
        begin
            l_rsp.data = `MEM_DATA_WIDTH'(take_bits(`MEM_DATA_WIDTH));
            l_rsp.tag  = `MEM_TAG_WIDTH'(take_bits(`MEM_TAG_WIDTH));
            e_rsp.data = `MEM_DATA_WIDTH'(take_bits(`MEM_DATA_WIDTH));
            e_rsp.tag  = `MEM_TAG_WIDTH'(take_bits(`MEM_TAG_WIDTH));
            hold       = int'(take_bits(2)) + 1;
            mem_rsp_ready = 1'b1;
            exp_q.push_back(l_rsp);
            exp_q.push_back(e_rsp);
            fork
                respond(1'b1, l_rsp, 1, 1'b1);
                respond(1'b0, e_rsp, 1, 1'b0);
            join
            // first cycle after the collision
            mem_rsp_ready = 1'b0;
            repeat (hold)
            begin
                #SETTLE;
                assert (mem_rsp_valid && (mem_rsp == e_rsp))
                    else report_mismatch($sformatf("buffered tag %02h not shown", e_rsp.tag));
                @(negedge clk);
            end
            mem_rsp_ready = 1'b1;
            wait_drained();
        end

        // start with data bit 0 clear is ignored
        wd    = 32'(take_bits(32));
        wd[0] = 1'b0;
        csr_write(START_OFS, wd, 4'hF);
        assert (gpu_reset) else report_mismatch("start with bit 0 clear released the core");

        // real start, one edge to release
        csr_write(START_OFS, 32'h1, 4'h1);
        assert (!gpu_reset) else report_mismatch("gpu_reset still high after start");

        // busy high then low, reset back one edge after the fall
        @(negedge clk);
        gpu_busy = 1'b1;
        repeat (4) @(negedge clk);
        gpu_busy = 1'b0;
        #SETTLE;
        assert (!gpu_reset) else report_mismatch("gpu_reset high before busy fall clocked");
        @(negedge clk);
        #SETTLE;
        assert (gpu_reset) else report_mismatch("gpu_reset not raised after busy fall");

        // strobed pc writes against a byte-merge model
        exp_pc = `PC_RESET_DEFAULT;
        for (int i = 0; i < 8; i++)
        begin
            wd   = 32'(take_bits(32));
            strb = 4'(take_bits(4));
            csr_write(PC_OFS, wd, strb);
            for (int b = 0; b < 4; b++)
            begin
                if (strb[b])
                begin
                    exp_pc[8*b +: 8] = wd[8*b +: 8];
                end
            end
            assert (gpu_pc_reset_val == exp_pc)
                else report_mismatch($sformatf("pc %08h, expected %08h",
                                               gpu_pc_reset_val, exp_pc));
            csr_read(PC_OFS, rd);
            assert (rd == exp_pc)
                else report_mismatch($sformatf("pc read %08h, expected %08h", rd, exp_pc));
        end

        // busy read returns last cycle's value
        for (int b = 1; b >= 0; b--)
        begin
            @(negedge clk);
            gpu_busy = b[0];
            @(negedge clk);
            gpu_busy     = ~b[0];
            csr_req.ren  = 1'b1;
            csr_req.addr = BUSY_OFS;
            #SETTLE;
            assert (csr_rdata == 32'(b))
                else report_mismatch($sformatf("busy read %08h, expected %0d", csr_rdata, b));
            @(negedge clk);
            csr_req.ren = 1'b0;
            gpu_busy    = 1'b0;
        end

        csr_read(START_OFS, rd);
        assert (rd == 32'h0) else report_mismatch($sformatf("start reg read %08h", rd));

        if (exp_q.size() != 0)
        begin
            report_problem("responses left undelivered at end of run");
        end
        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/gpu_mem_bridge.sv
`default_nettype none

`include "bridge_params.svh"

module gpu_mem_bridge
(
    input  logic                        clk,
    input  logic                        nRST,

    // core memory request
    input  logic                        mem_req_valid,
    input  bridge_pkg::mem_req_t        mem_req,
    output logic                        mem_req_ready,

    // core memory response
    output logic                        mem_rsp_valid,
    output bridge_pkg::mem_rsp_t        mem_rsp,
    input  logic                        mem_rsp_ready,

    // local responder
    output logic                        local_req_valid,
    output bridge_pkg::mem_req_t        local_req,
    input  logic                        local_req_ready,
    input  logic                        local_rsp_valid,
    input  bridge_pkg::mem_rsp_t        local_rsp,
    output logic                        local_rsp_ready,

    // external bus responder
    output logic                        ext_req_valid,
    output bridge_pkg::mem_req_t        ext_req,
    input  logic                        ext_req_ready,
    input  logic                        ext_rsp_valid,
    input  bridge_pkg::mem_rsp_t        ext_rsp,
    output logic                        ext_rsp_ready,

    // host registers
    input  bridge_pkg::csr_req_t        csr_req,
    output logic [`CSR_DATA_WIDTH-1:0]  csr_rdata,

    // core control
    input  logic                        gpu_busy,
    output logic                        gpu_reset,
    output logic [`CSR_DATA_WIDTH-1:0]  gpu_pc_reset_val
);

    //////////////////////////////////////////////////
    // request side
    //////////////////////////////////////////////////

    // payload fans out, only valid is steered
    assign local_req = mem_req;
    assign ext_req   = mem_req;

    mem_req_router router_i
    (
        .mem_req_valid   (mem_req_valid),
        .mem_req         (mem_req),
        .mem_req_ready   (mem_req_ready),
        .local_req_valid (local_req_valid),
        .ext_req_valid   (ext_req_valid),
        .local_req_ready (local_req_ready),
        .ext_req_ready   (ext_req_ready)
    );

    //////////////////////////////////////////////////
    // response side
    //////////////////////////////////////////////////

    // both responders see core back-pressure
    assign local_rsp_ready = mem_rsp_ready;
    assign ext_rsp_ready   = mem_rsp_ready;

    mem_rsp_merge merge_i
    (
        .clk             (clk),
        .nRST            (nRST),
        .local_rsp_valid (local_rsp_valid),
        .local_rsp       (local_rsp),
        .ext_rsp_valid   (ext_rsp_valid),
        .ext_rsp         (ext_rsp),
        .mem_rsp_valid   (mem_rsp_valid),
        .mem_rsp         (mem_rsp),
        .mem_rsp_ready   (mem_rsp_ready)
    );

    // host control of the core
    launch_ctrl launch_i
    (
        .clk              (clk),
        .nRST             (nRST),
        .csr_req          (csr_req),
        .csr_rdata        (csr_rdata),
        .gpu_busy         (gpu_busy),
        .gpu_reset        (gpu_reset),
        .gpu_pc_reset_val (gpu_pc_reset_val)
    );

endmodule

`default_nettype wire

// File: hdl/launch_ctrl.sv
`default_nettype none

`include "bridge_params.svh"

module launch_ctrl
(
    input  logic                        clk,
    input  logic                        nRST,

    // host register port
    input  bridge_pkg::csr_req_t        csr_req,
    output logic [`CSR_DATA_WIDTH-1:0]  csr_rdata,

    // core control
    input  logic                        gpu_busy,
    output logic                        gpu_reset,
    output logic [`CSR_DATA_WIDTH-1:0]  gpu_pc_reset_val
);

    import bridge_pkg::*;

    // word select starts above the byte offset
    localparam int SEL_LSB = 2;
    localparam logic [`CSR_ADDR_BITS-1:0] BUSY_OFS  = `CSR_BUSY_OFS;
    localparam logic [`CSR_ADDR_BITS-1:0] START_OFS = `CSR_START_OFS;
    localparam logic [`CSR_ADDR_BITS-1:0] PC_OFS    = `CSR_PC_OFS;

    // register decode
    logic [`CSR_ADDR_BITS-1:SEL_LSB] reg_sel;
    logic                            hit_busy;
    logic                            hit_start;
    logic                            hit_pc;

    // host write data, byte view for strobes
    csr_word_u                       wdata_u;

    // state
    logic                            busy_q;
    logic                            running_q;
    logic                            running_d;
    csr_word_u                       pc_q;
    csr_word_u                       pc_d;

    // events
    logic                            start_hit;
    logic                            busy_fall;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    assign reg_sel   = csr_req.addr[`CSR_ADDR_BITS-1:SEL_LSB];
    assign hit_busy  = (reg_sel == BUSY_OFS[`CSR_ADDR_BITS-1:SEL_LSB]);
    assign hit_start = (reg_sel == START_OFS[`CSR_ADDR_BITS-1:SEL_LSB]);
    assign hit_pc    = (reg_sel == PC_OFS[`CSR_ADDR_BITS-1:SEL_LSB]);

    assign wdata_u.word = csr_req.wdata;

    // start needs byte lane 0 enabled and bit 0 set
    assign start_hit = csr_req.wen & hit_start & csr_req.strobe[0]
                     & wdata_u.bytes[0][0];

    // core just finished its kernel
    assign busy_fall = busy_q & ~gpu_busy;

    //////////////////////////////////////////////////
    // reads
    //////////////////////////////////////////////////

    // start and unmapped offsets read zero
    always_comb
    begin
        csr_rdata = '0;
        if (csr_req.ren)
        begin
            if (hit_busy)
            begin
                csr_rdata = {{(`CSR_DATA_WIDTH-1){1'b0}}, busy_q};
            end
            else if (hit_pc)
            begin
                csr_rdata = pc_q.word;
            end
        end
    end

    //////////////////////////////////////////////////
    // writes and core reset FSM
    //////////////////////////////////////////////////

    // strobed byte merge into pc
    always_comb
    begin
        pc_d = pc_q;
        if (csr_req.wen && hit_pc)
        begin
            for (int i = 0; i < `CSR_DATA_WIDTH / 8; i++)
            begin
                if (csr_req.strobe[i])
                begin
                    pc_d.bytes[i] = wdata_u.bytes[i];
                end
            end
        end
    end

    // idle -> running on start, back on busy falling
    always_comb
    begin
        running_d = running_q;
        if (!running_q)
        begin
            if (start_hit)
            begin
                running_d = 1'b1;
            end
        end
        else if (busy_fall)
        begin
            running_d = 1'b0;
        end
    end

    always_ff @(posedge clk, negedge nRST)
    begin
        if (!nRST)
        begin
            busy_q    <= 1'b0;
            running_q <= 1'b0;
            pc_q.word <= `PC_RESET_DEFAULT;
        end
        else
        begin
            busy_q    <= gpu_busy;
            running_q <= running_d;
            pc_q      <= pc_d;
        end
    end

    // core held in reset while idle, async clear covers nRST
    assign gpu_reset        = ~running_q;
    assign gpu_pc_reset_val = pc_q.word;

endmodule

`default_nettype wire

// File: hdl/mem_rsp_merge.sv
`default_nettype none

module mem_rsp_merge
(
    input  logic                 clk,
    input  logic                 nRST,

    // local responder
    input  logic                 local_rsp_valid,
    input  bridge_pkg::mem_rsp_t local_rsp,

    // external responder
    input  logic                 ext_rsp_valid,
    input  bridge_pkg::mem_rsp_t ext_rsp,

    // merged stream to the core
    output logic                 mem_rsp_valid,
    output bridge_pkg::mem_rsp_t mem_rsp,
    input  logic                 mem_rsp_ready
);

    import bridge_pkg::*;

    // collision buffer, one entry
    logic     buf_valid;
    logic     buf_valid_d;
    mem_rsp_t buf_rsp;

    // buffer control
    logic     collide;
    logic     ext_behind_buf;
    logic     buf_load;
    logic     buf_shown;
    logic     buf_drain;

    //////////////////////////////////////////////////
    // output select
    //////////////////////////////////////////////////

    // local first, then buffer, then live external
    always_comb
    begin
        if (local_rsp_valid)
        begin
            mem_rsp_valid = 1'b1;
            mem_rsp       = local_rsp;
        end
        else if (buf_valid)
        begin
            mem_rsp_valid = 1'b1;
            mem_rsp       = buf_rsp;
        end
        else
        begin
            mem_rsp_valid = ext_rsp_valid;
            mem_rsp       = ext_rsp;
        end
    end

    //////////////////////////////////////////////////
    // buffer control
    //////////////////////////////////////////////////

    // both responders answer at once
    assign collide = local_rsp_valid & ext_rsp_valid;

    // external answer hidden behind the buffered entry
    assign ext_behind_buf = ext_rsp_valid & buf_valid & ~local_rsp_valid;

    // external side sees ready high as accepted
    // with ready low it holds its answer, nothing to capture
    assign buf_load = (collide | ext_behind_buf) & mem_rsp_ready;

    // entry on the output and taken by the core
    assign buf_shown = buf_valid & ~local_rsp_valid;
    assign buf_drain = buf_shown & mem_rsp_ready;

    always_comb
    begin
        buf_valid_d = buf_valid;
        if (buf_load)
        begin
            // refill wins over drain
            buf_valid_d = 1'b1;
        end
        else if (buf_drain)
        begin
            buf_valid_d = 1'b0;
        end
    end

    always_ff @(posedge clk, negedge nRST)
    begin
        if (!nRST)
        begin
            buf_valid <= 1'b0;
        end
        else
        begin
            buf_valid <= buf_valid_d;
        end
    end

    // payload only moves on a load
    always_ff @(posedge clk)
    begin
        if (buf_load)
        begin
            buf_rsp <= ext_rsp;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mem_req_router.sv
`default_nettype none

`include "bridge_params.svh"

module mem_req_router
(
    // from the core
    input  logic                 mem_req_valid,
    input  bridge_pkg::mem_req_t mem_req,
    output logic                 mem_req_ready,

    // steered valids
    output logic                 local_req_valid,
    output logic                 ext_req_valid,

    // responder readiness
    input  logic                 local_req_ready,
    input  logic                 ext_req_ready
);

    // full byte address width
    localparam int BYTE_ADDR_WIDTH = `MEM_ADDR_WIDTH + `LINE_OFFSET_BITS;
    localparam logic [BYTE_ADDR_WIDTH-1:0] LOCAL_BASE = `LOCAL_BASE_ADDR;

    logic [BYTE_ADDR_WIDTH-1:0] byte_addr;
    logic                       in_local;

    //////////////////////////////////////////////////
    // window decode
    //////////////////////////////////////////////////

    // line address back to byte address
    assign byte_addr = {mem_req.addr, {`LINE_OFFSET_BITS{1'b0}}};

    // upper bits pick the 16 KB window
    assign in_local = (byte_addr[BYTE_ADDR_WIDTH-1:`LOCAL_SPACE_BITS]
                       == LOCAL_BASE[BYTE_ADDR_WIDTH-1:`LOCAL_SPACE_BITS]);

    // one valid out, never both
    always_comb
    begin
        local_req_valid = 1'b0;
        ext_req_valid   = 1'b0;
        if (mem_req_valid)
        begin
            if (in_local)
            begin
                local_req_valid = 1'b1;
            end
            else
            begin
                ext_req_valid = 1'b1;
            end
        end
    end

    // target unknown to the core, so wait for both
    assign mem_req_ready = local_req_ready & ext_req_ready;

endmodule

`default_nettype wire

// File: hdl/bridge_pkg.sv
`default_nettype none

`include "bridge_params.svh"

package bridge_pkg;

    //////////////////////////////////////////////////
    // core memory request / response
    //////////////////////////////////////////////////

    // request payload, valid travels beside it
    typedef struct packed {
        // 1 = write
        logic                            rw;
        logic [`MEM_BYTEEN_WIDTH-1:0]    byteen;
        // line address
        logic [`MEM_ADDR_WIDTH-1:0]      addr;
        logic [`MEM_DATA_WIDTH-1:0]      data;
        logic [`MEM_TAG_WIDTH-1:0]       tag;
    } mem_req_t;

    // response payload
    typedef struct packed {
        logic [`MEM_DATA_WIDTH-1:0]      data;
        // echoes the request tag
        logic [`MEM_TAG_WIDTH-1:0]       tag;
    } mem_rsp_t;

    //////////////////////////////////////////////////
    // host register access
    //////////////////////////////////////////////////

    // one access per cycle, no wait states
    typedef struct packed {
        logic                            wen;
        logic                            ren;
        // byte offset inside the register block
        logic [`CSR_ADDR_BITS-1:0]       addr;
        logic [`CSR_DATA_WIDTH-1:0]      wdata;
        logic [`CSR_DATA_WIDTH/8-1:0]    strobe;
    } csr_req_t;

    // host word seen whole or as bytes
    // byte view serves strobed merges and the start bit
    typedef union packed {
        logic [`CSR_DATA_WIDTH-1:0]              word;
        logic [`CSR_DATA_WIDTH/8-1:0][7:0]       bytes;
    } csr_word_u;

endpackage

`default_nettype wire

// File: hdl/bridge_params.svh
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

//////////////////////////////////////////////////
// core memory port
//////////////////////////////////////////////////

// line address, one line per request
`define MEM_ADDR_WIDTH      29
`define MEM_DATA_WIDTH      64
`define MEM_BYTEEN_WIDTH    (`MEM_DATA_WIDTH / 8)
// byte offset inside one line
`define LINE_OFFSET_BITS    3
`define MEM_TAG_WIDTH       8

// local scratch window, 16 KB
`define LOCAL_BASE_ADDR     32'hF000_0000
`define LOCAL_SPACE_BITS    14

//////////////////////////////////////////////////
// host control/status registers
//////////////////////////////////////////////////

`define CSR_DATA_WIDTH      32
`define CSR_ADDR_BITS       14
`define CSR_BUSY_OFS        0
`define CSR_START_OFS       4
`define CSR_PC_OFS          8
// boot pc of the core, points at the scratch window
`define PC_RESET_DEFAULT    32'hF000_0000

`endif
